// File: tb.f
+incdir+src
src/replay_pkg.sv
src/replay_mem_if.sv
src/stream_capture.sv
src/replay_mem.sv
src/stream_replay.sv
src/pcap_replay_top.sv
testbench/replay_checker.sv
testbench/replay_sva.sv
testbench/tb_replay.sv

// File: Makefile
# Verilator build and run of the capture and replay testbench

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, fails if the log reports a failure"
	@echo "make clean  remove the build folder and the log"

test:
	verilator --binary --timing -j 0 -f tb.f --top-module tb_replay -Mdir obj_dir -o sim_replay
	./obj_dir/sim_replay +verilator+error+limit+100 > sim.log 2>&1; status=$$?; \
	cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "tests failed" sim.log; then \
	  echo "FAIL"; exit 1; \
	else \
	  echo "PASS"; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_replay.sv
// Testbench top for the capture and replay engine
// Drives LFSR stimulus, prints one line per test and a closing count

`timescale 1ns/1ns
`include "replay_cfg.svh"

module tb_replay;
  localparam int STRB_W = `REPLAY_DATA_W / 8;
  localparam int CNT_W = $clog2(`REPLAY_DEPTH) + 1;
  localparam int CAP_BEATS = 60;
  localparam int MAX_LOOPS = 15;
  localparam int OVERFILL = `REPLAY_DEPTH + 24;
  localparam int NEW_BEATS = 20;
  // Beats offered and replayed over all five tests
  localparam int TOTAL_BEATS = CAP_BEATS * (4 + MAX_LOOPS) + OVERFILL + `REPLAY_DEPTH
                               + 3 * NEW_BEATS;
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20;

  logic clk = 1'b0;
  logic rst, sw_rst, replay_start, replay_busy, replay_done;
  logic [`REPLAY_DATA_W-1:0] s_axis_tdata, m_axis_tdata;
  logic [STRB_W-1:0] s_axis_tstrb, m_axis_tstrb;
  logic s_axis_tvalid, s_axis_tready, s_axis_tlast;
  logic m_axis_tvalid, m_axis_tready, m_axis_tlast;
  logic [`REPLAY_LOOP_W-1:0] replay_loops;
  logic [CNT_W-1:0] capture_count;
  logic [31:0] lfsr = 32'h1a27_0402;
  int tb_errors = 0;
  int errors_mark = 0;
  int tests_run = 0;
  int tests_ok = 0;

  always #5 clk = ~clk;

  pcap_replay_top UUT (.*, .axi_aclk(clk));
  replay_checker chk (.*);

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    // x^32 + x^22 + x^2 + x + 1
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [63:0] draw_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr[0]};
      lfsr = galois_step(lfsr);
    end
    return v;
  endfunction

  task automatic feed_beats(input int beats, input int max_cycles, output int taken);
    int cycles;
    bit handshake;
    taken = 0;
    cycles = 0;
    while (taken < beats && cycles < max_cycles) begin
      // About one new beat in four waits an idle cycle first
      if (!s_axis_tvalid) begin
        if (draw_bits(2) != 64'd0) begin
          s_axis_tdata = draw_bits(`REPLAY_DATA_W);
          s_axis_tstrb = STRB_W'(draw_bits(STRB_W));
          s_axis_tlast = (draw_bits(3) == 64'd0);
          s_axis_tvalid = 1'b1;
        end
      end
      @(posedge clk);
      cycles++;
      handshake = s_axis_tvalid && s_axis_tready;
      #1;
      if (handshake) begin
        taken++;
        s_axis_tvalid = 1'b0;
      end
    end
    s_axis_tvalid = 1'b0;
  endtask

  task automatic start_replay(input logic [`REPLAY_LOOP_W-1:0] loops);
    replay_loops = loops;
    replay_start = 1'b1;
    @(posedge clk);
    #1 replay_start = 1'b0;
  endtask

  task automatic wait_done(input bit random_ready);
    bit seen_done;
    seen_done = 1'b0;
    while (!seen_done) begin
      if (random_ready) m_axis_tready = (draw_bits(1) != 64'd0);
      @(posedge clk);
      seen_done = replay_done;
      #1;
    end
    m_axis_tready = 1'b1;
    // Quiet cycles expose stray beats after done
    repeat (4) @(posedge clk);
    #1;
  endtask

  task automatic clear_capture();
    sw_rst = 1'b1;
    @(posedge clk);
    #1 sw_rst = 1'b0;
  endtask

  task automatic expect_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("mismatch %s expected %0h actual %0h", name, expected, actual);
      tb_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    int now_errors;
    now_errors = chk.errors + tb_errors;
    tests_run++;
    if (now_errors == errors_mark) begin
      tests_ok++;
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      $display("test %0d %s: %0d errors", tests_run, name, now_errors - errors_mark);
    end
    errors_mark = now_errors;
  endtask

  initial begin
    int taken;
    int count_before;
    logic [`REPLAY_LOOP_W-1:0] loops;
    rst = 1'b1;
    sw_rst = 1'b0;
    s_axis_tdata = '0;
    s_axis_tstrb = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast = 1'b0;
    m_axis_tready = 1'b1;
    replay_start = 1'b0;
    replay_loops = '0;
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;

    feed_beats(CAP_BEATS, CAP_BEATS * 4, taken);
    expect_value("accepted beats", CAP_BEATS, taken);
    expect_value("capture_count", taken, int'(capture_count));
    start_replay(1);
    wait_done(1'b0);
    finish_test("capture and single replay");

    do loops = `REPLAY_LOOP_W'(draw_bits(`REPLAY_LOOP_W)); while (loops == '0);
    start_replay(loops);
    wait_done(1'b1);
    finish_test($sformatf("replay of %0d passes under back-pressure", loops));

    // Source beats offered while the replay runs
    // Recording left by the first test
    count_before = taken;
    start_replay(2);
    fork
      feed_beats(CAP_BEATS, CAP_BEATS, taken);
      wait_done(1'b0);
    join
    expect_value("beats accepted while busy", 0, taken);
    expect_value("capture_count", count_before, int'(capture_count));
    finish_test("capture blocked during replay");

    clear_capture();
    feed_beats(OVERFILL, OVERFILL * 3, taken);
    expect_value("accepted beats", `REPLAY_DEPTH, taken);
    expect_value("capture_count", `REPLAY_DEPTH, int'(capture_count));
    start_replay(1);
    wait_done(1'b0);
    finish_test("full memory");

    clear_capture();
    expect_value("capture_count", 0, int'(capture_count));
    start_replay(3);
    wait_done(1'b0);
    feed_beats(NEW_BEATS, NEW_BEATS * 4, taken);
    expect_value("capture_count", NEW_BEATS, int'(capture_count));
    start_replay(0);
    wait_done(1'b0);
    start_replay(2);
    wait_done(1'b1);
    finish_test("software clear and empty replays");

    $display("tests run %0d, ok %0d, errors %0d", tests_run, tests_ok, chk.errors + tb_errors);
    if (chk.errors + tb_errors == 0 && tests_ok == tests_run) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("tests failed");
    $finish;
  end

endmodule

// File: testbench/replay_sva.sv
// Protocol assertions on the engine's top-level ports
// Bound into every pcap_replay_top instance

`timescale 1ns/1ns
`include "replay_cfg.svh"

module replay_sva (
  input logic                               axi_aclk,
  input logic                               rst,
  input logic [`REPLAY_DATA_W-1:0]          m_axis_tdata,
  input logic [`REPLAY_DATA_W/8-1:0]        m_axis_tstrb,
  input logic                               m_axis_tvalid,
  input logic                               m_axis_tready,
  input logic                               m_axis_tlast,
  input logic                               s_axis_tready,
  input logic                               replay_busy,
  input logic                               replay_done,
  input logic [$clog2(`REPLAY_DEPTH):0]     capture_count
);

  // Stalled master beat holds until taken
  assert property (@(posedge axi_aclk) disable iff (rst)
    (m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid && $stable(m_axis_tdata) &&
      $stable(m_axis_tstrb) && $stable(m_axis_tlast)))
    else $error("master beat changed while stalled");

  assert property (@(posedge axi_aclk) disable iff (rst) replay_busy |-> !s_axis_tready)
    else $error("s_axis_tready high during a replay");

  assert property (@(posedge axi_aclk) disable iff (rst) replay_done |=> !replay_done)
    else $error("replay_done longer than one cycle");

  assert property (@(posedge axi_aclk) disable iff (rst) capture_count <= `REPLAY_DEPTH)
    else $error("capture_count above memory depth");

endmodule

bind pcap_replay_top replay_sva sva_inst (
  .axi_aclk (axi_aclk), .rst (rst),
  .m_axis_tdata (m_axis_tdata), .m_axis_tstrb (m_axis_tstrb), .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tready (m_axis_tready), .m_axis_tlast (m_axis_tlast), .s_axis_tready (s_axis_tready),
  .replay_busy (replay_busy), .replay_done (replay_done), .capture_count (capture_count)
);

// File: testbench/replay_checker.sv
// Scoreboard for the capture and replay engine
// Models the recording from slave handshakes and checks every replayed beat

`timescale 1ns/1ns
`include "replay_cfg.svh"

module replay_checker #(
  parameter int CNT_W = $clog2(`REPLAY_DEPTH) + 1
) (
  input logic                        clk,
  input logic                        rst,
  input logic                        sw_rst,
  input logic [`REPLAY_DATA_W-1:0]   s_axis_tdata,
  input logic [`REPLAY_DATA_W/8-1:0] s_axis_tstrb,
  input logic                        s_axis_tvalid,
  input logic                        s_axis_tready,
  input logic                        s_axis_tlast,
  input logic [`REPLAY_DATA_W-1:0]   m_axis_tdata,
  input logic [`REPLAY_DATA_W/8-1:0] m_axis_tstrb,
  input logic                        m_axis_tvalid,
  input logic                        m_axis_tready,
  input logic                        m_axis_tlast,
  input logic                        replay_start,
  input logic [`REPLAY_LOOP_W-1:0]   replay_loops,
  input logic                        replay_busy,
  input logic                        replay_done,
  input logic [CNT_W-1:0]            capture_count
);
  localparam int DATA_W = `REPLAY_DATA_W;
  localparam int STRB_W = DATA_W / 8;

  // Beat layout {last, strobe, data}
  logic [DATA_W+STRB_W:0] model [$];
  logic [DATA_W+STRB_W:0] got;
  logic [DATA_W+STRB_W:0] held;
  logic [DATA_W+STRB_W:0] want;
  int errors = 0;
  int expected_beats = 0;
  int seen = 0;
  bit active = 1'b0;
  bit stalled = 1'b0;

  task automatic compare_field(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s expected %0h actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic flag_error(input string what);
    $display("error at %0t ns: %s", $time, what);
    errors++;
  endtask

  assign got = {m_axis_tlast, m_axis_tstrb, m_axis_tdata};

  always @(posedge clk) begin
    if (rst) begin
      model.delete();
      active = 1'b0;
      stalled = 1'b0;
    end else begin
      compare_field("capture_count", DATA_W'(model.size()), DATA_W'(capture_count));
      // Busy from the edge after a non-empty start until done
      compare_field("replay_busy", DATA_W'(active && !replay_done && expected_beats != 0),
                    DATA_W'(replay_busy));
      if (s_axis_tready && replay_busy) flag_error("s_axis_tready high during a replay");
      // A stalled beat stays on the bus unchanged
      if (stalled && (!m_axis_tvalid || got !== held)) begin
        flag_error("master beat changed while stalled");
      end
      stalled = m_axis_tvalid && !m_axis_tready;
      held = got;
      if (m_axis_tvalid && m_axis_tready) begin
        if (!active || seen >= expected_beats) begin
          flag_error("master beat outside of a replay");
        end else begin
          // Passes repeat the recording from address zero
          want = model[seen % model.size()];
          compare_field("m_axis_tdata", want[DATA_W-1:0], m_axis_tdata);
          compare_field("m_axis_tstrb", DATA_W'(want[DATA_W +: STRB_W]), DATA_W'(m_axis_tstrb));
          compare_field("m_axis_tlast", DATA_W'(want[DATA_W+STRB_W]), DATA_W'(m_axis_tlast));
          seen++;
        end
      end
      if (replay_done) begin
        if (!active) flag_error("replay_done without a running replay");
        else if (seen != expected_beats)
          flag_error($sformatf("replay_done after %0d of %0d beats", seen, expected_beats));
        active = 1'b0;
      end
      if (replay_start && !replay_busy) begin
        active = 1'b1;
        seen = 0;
        expected_beats = model.size() * int'(replay_loops);
      end
      if (sw_rst && !replay_busy) model.delete();
      else if (s_axis_tvalid && s_axis_tready)
        model.push_back({s_axis_tlast, s_axis_tstrb, s_axis_tdata});
      if (model.size() > `REPLAY_DEPTH) flag_error("more beats stored than the memory holds");
    end
  end

endmodule

// File: src/pcap_replay_top.sv
// Packet capture and replay engine, single clock
// Slave stream fills the memory, a start strobe plays it back on the master stream

`timescale 1ns/1ns
`include "replay_cfg.svh"

module pcap_replay_top (
  // Global
  input  logic                          axi_aclk,
  input  logic                          rst,
  input  logic                          sw_rst,

  // Slave stream, capture input
  input  logic [`REPLAY_DATA_W-1:0]     s_axis_tdata,
  input  logic [replay_pkg::STRB_W-1:0] s_axis_tstrb,
  input  logic                          s_axis_tvalid,
  output logic                          s_axis_tready,
  input  logic                          s_axis_tlast,

  // Master stream, replay output
  output logic [`REPLAY_DATA_W-1:0]     m_axis_tdata,
  output logic [replay_pkg::STRB_W-1:0] m_axis_tstrb,
  output logic                          m_axis_tvalid,
  input  logic                          m_axis_tready,
  output logic                          m_axis_tlast,

  // Control and status
  input  logic                          replay_start,
  input  logic [`REPLAY_LOOP_W-1:0]     replay_loops,
  output logic                          replay_busy,
  output logic                          replay_done,
  output logic [replay_pkg::CNT_W-1:0]  capture_count
);
  import replay_pkg::*;

  mem_wr_if wr_if ();
  mem_rd_if rd_if ();

  assign capture_count = wr_if.count;

  stream_capture capture_inst (
    .axi_aclk      (axi_aclk),
    .rst           (rst),
    .sw_rst        (sw_rst),
    .busy          (replay_busy),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tstrb  (s_axis_tstrb),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tlast  (s_axis_tlast),
    .wr            (wr_if.capture)
  );

  replay_mem mem_inst (
    .axi_aclk (axi_aclk),
    .wr       (wr_if.mem),
    .rd       (rd_if.mem)
  );

  stream_replay replay_inst (
    .axi_aclk      (axi_aclk),
    .rst           (rst),
    .replay_start  (replay_start),
    .replay_loops  (replay_loops),
    .busy          (replay_busy),
    .replay_done   (replay_done),
    .wr            (wr_if.replay),
    .rd            (rd_if.replay),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tstrb  (m_axis_tstrb),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast)
  );

endmodule

// File: src/stream_replay.sv
// Replay side of the engine
// Streams the recording out in address order for the requested number of passes

`timescale 1ns/1ns
`include "replay_cfg.svh"

module stream_replay (
  input  logic                          axi_aclk,
  input  logic                          rst,
  input  logic                          replay_start,
  input  logic [`REPLAY_LOOP_W-1:0]     replay_loops,
  output logic                          busy,
  output logic                          replay_done,

  mem_wr_if.replay                      wr,
  mem_rd_if.replay                      rd,

  output logic [`REPLAY_DATA_W-1:0]     m_axis_tdata,
  output logic [replay_pkg::STRB_W-1:0] m_axis_tstrb,
  output logic                          m_axis_tvalid,
  input  logic                          m_axis_tready,
  output logic                          m_axis_tlast
);
  import replay_pkg::*;

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_PLAY = 2'd1;
  localparam logic [1:0] S_FINISH = 2'd2;

  logic [1:0]               state;
  logic [ADDR_W-1:0]        raddr;
  logic [`REPLAY_LOOP_W-1:0] pass_left;
  logic [CNT_W-1:0]         rec_count;
  logic [1:0]               inflight;

  // Two-entry output buffer
  logic [WORD_W-1:0]        obuf [2];
  logic                     obuf_wp;
  logic                     obuf_rp;
  logic [1:0]               occ;
  logic [WORD_W-1:0]        head;

  logic                     idle;
  logic                     pop;
  logic                     room;
  logic                     empty_run;
  logic                     wrap;
  logic                     last_read;
  logic                     drain_end;
  logic [ADDR_W-1:0]        cur_addr;
  logic [CNT_W-1:0]         cur_count;
  logic [`REPLAY_LOOP_W-1:0] cur_left;

  assign idle = (state == S_IDLE);
  assign busy = !idle;
  assign pop = m_axis_tvalid && m_axis_tready;

  // While idle the first read goes out in the start cycle itself
  assign cur_addr = idle ? '0 : raddr;
  assign cur_count = idle ? wr.count : rec_count;
  assign cur_left = idle ? replay_loops : pass_left;

  assign empty_run = (replay_loops == '0) || (wr.count == '0);

  // Buffered plus outstanding words must fit in two slots after this cycle
  assign room = ({1'b0, occ} + {1'b0, inflight}) < (3'd2 + {2'b0, pop});

  assign rd.en = room && ((idle && replay_start && !empty_run) || (state == S_PLAY));
  assign rd.addr = cur_addr;

  assign wrap = ((CNT_W'(cur_addr) + CNT_W'(1)) == cur_count);
  assign last_read = rd.en && wrap && (cur_left == `REPLAY_LOOP_W'(1));

  // Final beat leaves with nothing else pending
  assign drain_end = (state == S_FINISH) && pop &&
                     (({1'b0, occ} + {1'b0, inflight}) == 3'd1);

  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      state <= S_IDLE;
      replay_done <= 1'b0;
      raddr <= '0;
      pass_left <= '0;
      rec_count <= '0;
      inflight <= '0;
      obuf_wp <= 1'b0;
      obuf_rp <= 1'b0;
      occ <= '0;
    end else begin
      replay_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (replay_start) begin
            rec_count <= wr.count;
            if (empty_run) begin
              replay_done <= 1'b1;
            end else if (last_read) begin
              state <= S_FINISH;
            end else begin
              state <= S_PLAY;
            end
          end
        end
        S_PLAY: begin
          if (last_read) begin
            state <= S_FINISH;
          end
        end
        S_FINISH: begin
          if (drain_end) begin
            state <= S_IDLE;
            replay_done <= 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase

      // Address walk, wrapping to zero at the end of each pass
      if (rd.en) begin
        if (wrap) begin
          raddr <= '0;
          pass_left <= cur_left - `REPLAY_LOOP_W'(1);
        end else begin
          raddr <= cur_addr + ADDR_W'(1);
          pass_left <= cur_left;
        end
      end

      inflight <= inflight + 2'(rd.en) - 2'(rd.valid);
      occ <= occ + 2'(rd.valid) - 2'(pop);
      if (rd.valid) begin
        obuf_wp <= !obuf_wp;
      end
      if (pop) begin
        obuf_rp <= !obuf_rp;
      end
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (rd.valid) begin
      obuf[obuf_wp] <= rd.word;
    end
  end

  // Unpack the head entry onto the master stream
  assign head = obuf[obuf_rp];
  assign m_axis_tvalid = (occ != 2'd0);
  assign m_axis_tdata = head[`REPLAY_DATA_W-1:0];
  assign m_axis_tstrb = head[STRB_LSB +: STRB_W];
  assign m_axis_tlast = head[LAST_POS];

endmodule

// File: src/replay_mem.sv
// Recording memory, one word per captured beat
// One write port, one read port with a registered answer and valid flag

`timescale 1ns/1ns
`include "replay_cfg.svh"

module replay_mem (
  input  logic  axi_aclk,
  mem_wr_if.mem wr,
  mem_rd_if.mem rd
);
  import replay_pkg::*;

  logic [WORD_W-1:0] mem [`REPLAY_DEPTH];

  // Write port
  always_ff @(posedge axi_aclk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.word;
    end
  end

  // Read port, answer lands one cycle after the request
  always_ff @(posedge axi_aclk) begin
    if (rd.en) begin
      rd.word <= mem[rd.addr];
    end
  end

  always_ff @(posedge axi_aclk) begin
    rd.valid <= rd.en;
  end

endmodule

// File: src/stream_capture.sv
// Capture side of the engine
// Stores each accepted slave beat at the next free memory address

`timescale 1ns/1ns
`include "replay_cfg.svh"

module stream_capture (
  input  logic                          axi_aclk,
  input  logic                          rst,
  input  logic                          sw_rst,
  input  logic                          busy,

  input  logic [`REPLAY_DATA_W-1:0]     s_axis_tdata,
  input  logic [replay_pkg::STRB_W-1:0] s_axis_tstrb,
  input  logic                          s_axis_tvalid,
  output logic                          s_axis_tready,
  input  logic                          s_axis_tlast,

  mem_wr_if.capture                     wr
);
  import replay_pkg::*;

  // Write pointer doubles as the stored beat count
  logic [CNT_W-1:0] wr_ptr;
  logic             armed;
  logic             full;
  logic             accept;

  assign full = (wr_ptr == CNT_W'(`REPLAY_DEPTH));

  // Ready only once out of reset, while idle and with space left
  assign s_axis_tready = armed && !busy && !full;
  assign accept = s_axis_tvalid && s_axis_tready;

  assign wr.en = accept;
  assign wr.addr = wr_ptr[ADDR_W-1:0];
  assign wr.count = wr_ptr;

  // Pack the beat into one memory word
  always_comb begin
    wr.word = '0;
    wr.word[`REPLAY_DATA_W-1:0] = s_axis_tdata;
    wr.word[STRB_LSB +: STRB_W] = s_axis_tstrb;
    wr.word[LAST_POS] = s_axis_tlast;
  end

  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      wr_ptr <= '0;
      armed <= 1'b0;
    end else begin
      armed <= 1'b1;
      // Software clear only takes effect while no replay runs
      if (sw_rst && !busy) begin
        wr_ptr <= '0;
      end else if (accept) begin
        wr_ptr <= wr_ptr + CNT_W'(1);
      end
    end
  end

endmodule

// File: src/replay_mem_if.sv
// Write and read paths of the recording memory
// Reads answer one cycle after en; writes land in the cycle en is high

`timescale 1ns/1ns

interface mem_wr_if;
  import replay_pkg::*;

  logic              en;
  logic [ADDR_W-1:0] addr;
  logic [WORD_W-1:0] word;
  // Number of stored beats, also the next write address
  logic [CNT_W-1:0]  count;

  modport capture (output en, output addr, output word, output count);
  modport mem (input en, input addr, input word);
  modport replay (input count);
endinterface

interface mem_rd_if;
  import replay_pkg::*;

  logic              en;
  logic [ADDR_W-1:0] addr;
  logic [WORD_W-1:0] word;
  logic              valid;

  modport replay (output en, output addr, input word, input valid);
  modport mem (input en, input addr, output word, output valid);
endinterface

// File: src/replay_pkg.sv
// Constants derived from the build-time sizes
// Memory word layout is {last, strobe, data}, data in the low bits

`include "replay_cfg.svh"

package replay_pkg;

  // One strobe bit per data byte
  localparam int STRB_W = `REPLAY_DATA_W / 8;

  localparam int ADDR_W = $clog2(`REPLAY_DEPTH);

  // One extra bit so a full memory can be counted
  localparam int CNT_W = ADDR_W + 1;

  // Field positions inside a stored word
  localparam int STRB_LSB = `REPLAY_DATA_W;
  localparam int LAST_POS = STRB_LSB + STRB_W;
  localparam int WORD_W = LAST_POS + 1;

endpackage

// File: src/replay_cfg.svh
// Build-time sizes of the capture and replay engine
// Included by the package and by any module that sizes stream ports or memory

`ifndef REPLAY_CFG_SVH
`define REPLAY_CFG_SVH

// Stream data width in bits, a whole number of bytes
`define REPLAY_DATA_W 64

// Stored beats, one memory word each
`define REPLAY_DEPTH 256

// Width of the replay loop count
`define REPLAY_LOOP_W 4

`endif
